/* src/spw_tx_pkg.sv */
// SpaceWire transmit definitions shared by the character pipeline stages
`default_nettype none

package spw_tx_pkg;

	// ------------------------------
	// Character kinds
	// ------------------------------

	// Character currently held by the selector stage
	typedef enum logic [2:0] {
		char_null,
		char_fct,
		char_data,
		char_eop,
		char_eep
	} tx_char_kind_e;

	// ------------------------------
	// Credit stage FSMs
	// ------------------------------

	// Freed-slot accumulator, holds while a request level stays high
	typedef enum logic [0:0] {
		acc_idle,
		acc_hold
	} fct_acc_state_e;

	// Credit hand-out machine
	typedef enum logic [1:0] {
		out_idle,
		out_send,
		out_wait
	} fct_out_state_e;

	// Saturating credit count, also the initial grant
	localparam logic [2:0] fct_credit_max = 3'd7;

	// ------------------------------
	// Code word sizes
	// ------------------------------

	// Control character: parity, flag, two bits
	localparam logic [3:0] len_ctrl = 4'd4;
	// Data character: parity, flag, eight bits
	localparam logic [3:0] len_data = 4'd10;
	// Width of the code word bus between encoder and serializer
	localparam int code_width = 14;

endpackage

`default_nettype wire

/* src/tx_fct_send.sv */
// Flow-control credit stage, batches freed receive slots into FCT credits for transmission
`timescale 1ns/100ps
`default_nettype none

module tx_fct_send
(
	input wire pclk_tx,
	input wire enable_tx,
	input wire send_null_tx,
	input wire send_fct_now,
	input wire fct_sent,
	output logic [2:0] fct_flag_p
);

	import spw_tx_pkg::*;

	// Freed-slot count from the receiver, saturating
	logic [2:0] fct_flag;
	// One-cycle clear after a batch moved out
	logic clear_fct_flag;
	// Batch ready to move to the pending count
	logic batch_ready;

	fct_acc_state_e acc_state;
	fct_acc_state_e acc_next;
	fct_out_state_e out_state;
	fct_out_state_e out_next;

	// Full count and no request in flight
	assign batch_ready = !send_fct_now && (fct_flag == fct_credit_max);

	// ------------------------------
	// Accumulating FSM
	// ------------------------------

	// Counts one slot batch per request, ignores a held level
	always_comb
	begin
		acc_next = acc_state;
		case (acc_state)
			acc_idle:
			begin
				if (send_fct_now)
					acc_next = acc_hold;
			end
			acc_hold:
			begin
				if (!send_fct_now)
					acc_next = acc_idle;
			end
			default:
				acc_next = acc_idle;
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			acc_state <= acc_idle;
			fct_flag <= 3'd0;
		end
		else if (send_null_tx)
		begin
			acc_state <= acc_next;
			// Clear wins over a request in the same cycle
			if (acc_state == acc_idle)
			begin
				if (clear_fct_flag)
					fct_flag <= 3'd0;
				else if (send_fct_now && (fct_flag < fct_credit_max))
					fct_flag <= fct_flag + 3'd1;
			end
		end
	end

	// ------------------------------
	// Hand-out FSM
	// ------------------------------

	always_comb
	begin
		out_next = out_state;
		case (out_state)
			out_idle:
			begin
				if (batch_ready)
					out_next = out_send;
			end
			out_send:
			begin
				if (fct_sent)
					out_next = out_wait;
			end
			out_wait:
			begin
				// Back to sending while credits remain
				if (!fct_sent)
				begin
					if (fct_flag_p != 3'd0)
						out_next = out_send;
					else
						out_next = out_idle;
				end
			end
			default:
				out_next = out_idle;
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			// Initial grant, link start sends a full batch
			out_state <= out_send;
			fct_flag_p <= fct_credit_max;
			clear_fct_flag <= 1'b0;
		end
		else if (send_null_tx)
		begin
			out_state <= out_next;
			clear_fct_flag <= 1'b0;
			case (out_state)
				out_idle:
				begin
					// Take the whole batch and empty the accumulator
					if (batch_ready)
					begin
						fct_flag_p <= fct_flag;
						clear_fct_flag <= 1'b1;
					end
					else
						fct_flag_p <= 3'd0;
				end
				out_send:
				begin
					// One credit per FCT taken by the serializer
					if (fct_sent && (fct_flag_p != 3'd0))
						fct_flag_p <= fct_flag_p - 3'd1;
				end
				default:
					fct_flag_p <= fct_flag_p;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/tx_char_select.sv */
// Character selector stage, picks FCT, N-char or NULL and holds it for the encoder
`timescale 1ns/100ps
`default_nettype none

module tx_char_select
#(
	parameter int data_width = 8
)
(
	input wire pclk_tx,
	input wire enable_tx,
	input wire send_null_tx,
	input wire send_fct_tx,
	input wire send_char_tx,
	input wire tx_valid,
	input wire [data_width-1:0] tx_data,
	input wire tx_eop,
	input wire [2:0] fct_flag_p,
	input wire char_load,
	output spw_tx_pkg::tx_char_kind_e char_kind,
	output logic [data_width-1:0] char_data,
	output logic fct_sent,
	output logic tx_ready
);

	import spw_tx_pkg::*;

	// Credit left once a held FCT leaves
	logic fct_avail;
	// Next character comes from the source
	logic nchar_next;
	tx_char_kind_e kind_next;

	// Held FCT taken by the serializer this cycle
	assign fct_sent = char_load && (char_kind == char_fct);

	// The FCT leaving now is still counted in fct_flag_p
	assign fct_avail = fct_flag_p > {2'b00, fct_sent};

	// ------------------------------
	// Next character
	// ------------------------------

	// FCT first, then N-char, NULL as filler
	always_comb
	begin
		nchar_next = 1'b0;
		if (send_fct_tx && fct_avail)
			kind_next = char_fct;
		else if (send_char_tx && tx_valid)
		begin
			nchar_next = 1'b1;
			// Port char_data hides the enum value, so scope it
			if (!tx_eop)
				kind_next = spw_tx_pkg::char_data;
			else if (tx_data[0])
				kind_next = char_eep;
			else
				kind_next = char_eop;
		end
		else
			kind_next = char_null;
	end

	// Source character taken into the hold register
	assign tx_ready = char_load && nchar_next;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			char_kind <= char_null;
		else if (send_null_tx && char_load)
			char_kind <= kind_next;
	end

	// Payload follows the kind, EOP and EEP keep tx_data too
	always_ff @(posedge pclk_tx)
	begin
		if (send_null_tx && char_load && nchar_next)
			char_data <= tx_data;
	end

endmodule

`default_nettype wire

/* src/tx_char_encode.sv */
// Character encoder stage, builds parity-extended code words with running odd parity
`timescale 1ns/100ps
`default_nettype none

module tx_char_encode
#(
	parameter int data_width = 8
)
(
	input wire pclk_tx,
	input wire enable_tx,
	input wire send_null_tx,
	input wire char_load,
	input wire spw_tx_pkg::tx_char_kind_e char_kind,
	input wire [data_width-1:0] char_data,
	output logic [spw_tx_pkg::code_width-1:0] code_word,
	output logic [3:0] code_len
);

	import spw_tx_pkg::*;

	// Data bits carried by an N-char
	localparam int payload_bits = len_data - 2;

	// Ones parity of the previous character's payload
	logic prev_par;
	// Ones parity of this character's payload
	logic payload_par;
	logic [payload_bits-1:0] data_ext;

	// ------------------------------
	// Code word, LSB sent first
	// ------------------------------

	// Bit 0 parity, bit 1 flag, then payload
	// Parity covers previous payload plus this parity and flag
	always_comb
	begin
		data_ext = '0;
		data_ext[data_width-1:0] = char_data;
		code_word = '0;
		code_len = len_ctrl;
		payload_par = 1'b0;
		case (char_kind)
			spw_tx_pkg::char_data:
			begin
				// Flag 0, so parity inverts
				code_word[0] = ~prev_par;
				code_word[1] = 1'b0;
				code_word[payload_bits+1:2] = data_ext;
				code_len = len_data;
				payload_par = ^data_ext;
			end
			char_fct:
				code_word[3:0] = {2'b00, 1'b1, prev_par};
			char_eop:
			begin
				code_word[3:0] = {1'b0, 1'b1, 1'b1, prev_par};
				payload_par = 1'b1;
			end
			char_eep:
			begin
				code_word[3:0] = {1'b1, 1'b0, 1'b1, prev_par};
				payload_par = 1'b1;
			end
			default:
			begin
				// NULL is ESC then FCT
				// FCT half sees the ESC payload 11, even
				code_word[7:0] = {4'b0010, 3'b111, prev_par};
				code_len = len_ctrl + len_ctrl;
			end
		endcase
	end

	// Payload parity moves on as the serializer takes the word
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			prev_par <= 1'b0;
		else if (send_null_tx && char_load)
			prev_par <= payload_par;
	end

endmodule

`default_nettype wire

/* src/tx_ds_serializer.sv */
// Data-strobe serializer stage, shifts code words onto the dout/sout pair
`timescale 1ns/100ps
`default_nettype none

module tx_ds_serializer
(
	input wire pclk_tx,
	input wire enable_tx,
	input wire send_null_tx,
	input wire [spw_tx_pkg::code_width-1:0] code_word,
	input wire [3:0] code_len,
	output logic dout,
	output logic sout,
	output logic char_load
);

	import spw_tx_pkg::*;

	// Bits still queued behind the one on dout
	logic [code_width-1:0] shift_reg;
	// Count of queued bits, zero on the last bit of a word
	logic [3:0] bits_left;
	// Bit going onto dout at the next edge
	logic next_bit;

	// Last bit on the wire, next word loads at this edge
	assign char_load = send_null_tx && (bits_left == 4'd0);

	assign next_bit = char_load ? code_word[0] : shift_reg[0];

	// ------------------------------
	// Wire pair
	// ------------------------------

	// Strobe toggles when data repeats
	// so exactly one wire changes per bit
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			dout <= 1'b0;
			sout <= 1'b0;
			bits_left <= 4'd0;
		end
		else if (send_null_tx)
		begin
			dout <= next_bit;
			if (next_bit == dout)
				sout <= ~sout;
			if (char_load)
				bits_left <= code_len - 4'd1;
			else
				bits_left <= bits_left - 4'd1;
		end
	end

	// Shift register, bit 0 goes out first
	always_ff @(posedge pclk_tx)
	begin
		if (send_null_tx)
		begin
			if (char_load)
				shift_reg <= code_word >> 1;
			else
				shift_reg <= shift_reg >> 1;
		end
	end

endmodule

`default_nettype wire

/* src/spw_tx_top.sv */
// SpaceWire transmit top level, credit, select, encode and serialize stages in a chain
`timescale 1ns/100ps
`default_nettype none

module spw_tx_top
#(
	parameter int data_width = 8
)
(
	input wire pclk_tx,
	input wire enable_tx,
	input wire send_null_tx,
	input wire send_fct_tx,
	input wire send_char_tx,
	input wire send_fct_now,
	input wire tx_valid,
	input wire [data_width-1:0] tx_data,
	input wire tx_eop,
	output logic dout,
	output logic sout,
	output logic tx_ready,
	output logic [2:0] fct_credit
);

	import spw_tx_pkg::*;

	// Credit stage to selector
	logic [2:0] fct_flag_p;
	logic fct_sent;
	// Serializer takes a word
	logic char_load;
	// Held character
	tx_char_kind_e char_kind;
	logic [data_width-1:0] char_data;
	// Encoder to serializer
	logic [code_width-1:0] code_word;
	logic [3:0] code_len;

	// Pending FCT count seen outside
	assign fct_credit = fct_flag_p;

	tx_fct_send u_fct_send (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.send_fct_now(send_fct_now),
		.fct_sent(fct_sent),
		.fct_flag_p(fct_flag_p)
	);

	tx_char_select #(.data_width(data_width)) u_char_select (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.send_fct_tx(send_fct_tx),
		.send_char_tx(send_char_tx),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_eop(tx_eop),
		.fct_flag_p(fct_flag_p),
		.char_load(char_load),
		.char_kind(char_kind),
		.char_data(char_data),
		.fct_sent(fct_sent),
		.tx_ready(tx_ready)
	);

	tx_char_encode #(.data_width(data_width)) u_char_encode (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.char_load(char_load),
		.char_kind(char_kind),
		.char_data(char_data),
		.code_word(code_word),
		.code_len(code_len)
	);

	tx_ds_serializer u_ds_serializer (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.code_word(code_word),
		.code_len(code_len),
		.dout(dout),
		.sout(sout),
		.char_load(char_load)
	);

endmodule

`default_nettype wire

/* dv/spw_tx_tb.sv */
// SpaceWire transmit testbench, table-driven stimulus with a data-strobe decoder and checks
`timescale 1ns/100ps
`default_nettype none

module spw_tx_tb;

	import spw_tx_pkg::*;

	localparam int data_width = 8;
	localparam int num_entries = 5;

	logic pclk_tx = 1'b0;
	logic enable_tx;
	logic send_null_tx;
	logic send_fct_tx;
	logic send_char_tx;
	logic send_fct_now;
	logic tx_valid;
	logic [data_width-1:0] tx_data;
	logic tx_eop;
	logic dout;
	logic sout;
	logic tx_ready;
	logic [2:0] fct_credit;

	// ------------------------------
	// Stimulus table
	// ------------------------------

	// Per entry: FCT enable, N-char enable, send_fct_now pulses, N-chars, pause
	bit t_fct [num_entries] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
	bit t_char [num_entries] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	int t_pulses [num_entries] = '{0, 0, 8, 0, 0};
	int t_nchar [num_entries] = '{0, 0, 0, 4, 4};
	bit t_pause [num_entries] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	// Bit 8 is tx_eop, data bit 0 then picks EEP
	logic [8:0] t_chars [num_entries][4] = '{
		'{9'h000, 9'h000, 9'h000, 9'h000},
		'{9'h000, 9'h000, 9'h000, 9'h000},
		'{9'h000, 9'h000, 9'h000, 9'h000},
		'{9'h0A5, 9'h03C, 9'h100, 9'h0FF},
		'{9'h012, 9'h07E, 9'h101, 9'h0C9}
	};

	int seed = 16706;
	int kind_errors = 0;
	int data_errors = 0;
	int credit_errors = 0;
	int other_errors = 0;
	// Expected pending FCT count
	int model_credit = 7;
	int ready_count;

	// Decoder state
	logic prev_d;
	logic prev_s;
	logic [9:0] bits;
	int nb;
	int len;
	logic run_par;
	logic esc_seen;
	int nulls_in_row;
	tx_char_kind_e got_kind [$];
	logic [data_width-1:0] got_data [$];
	tx_char_kind_e exp_kind [$];
	logic [data_width-1:0] exp_data [$];

	spw_tx_top #(.data_width(data_width)) uut (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_null_tx(send_null_tx),
		.send_fct_tx(send_fct_tx),
		.send_char_tx(send_char_tx),
		.send_fct_now(send_fct_now),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_eop(tx_eop),
		.dout(dout),
		.sout(sout),
		.tx_ready(tx_ready),
		.fct_credit(fct_credit)
	);

	always #4 pclk_tx = ~pclk_tx;

	// ------------------------------
	// Compare tasks
	// ------------------------------

	task automatic check_kind(input tx_char_kind_e got, input tx_char_kind_e exp);
		if (got !== exp)
		begin
			kind_errors++;
			$display("** Error char_kind: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_data(input logic [data_width-1:0] got,
		input logic [data_width-1:0] exp);
		if (got !== exp)
		begin
			data_errors++;
			$display("** Error tx_data: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_credit(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
		begin
			credit_errors++;
			$display("** Error fct_credit: got %h expected %h", got, exp);
		end
	endtask

	// ------------------------------
	// Data-strobe decoder
	// ------------------------------

	task automatic report_other(input string msg);
		other_errors++;
		$display("%s", msg);
	endtask

	// Full character in bits, LSB first: parity, flag, payload
	task automatic decode_char();
		logic par_ok;
		par_ok = run_par ^ bits[0] ^ bits[1];
		if (!bits[1])
		begin
			if (!par_ok)
				report_other("Parity error on a data character");
			if (esc_seen)
				report_other("ESC followed by a data character");
			esc_seen = 1'b0;
			got_kind.push_back(char_data);
			got_data.push_back(bits[9:2]);
			run_par = ^bits[9:2];
			nulls_in_row = 0;
		end
		else
		begin
			if (!par_ok)
				report_other("Parity error on a control character");
			run_par = bits[2] ^ bits[3];
			if (bits[3:2] == 2'b11)
			begin
				if (esc_seen)
					report_other("Two ESC codes in a row");
				esc_seen = 1'b1;
			end
			else if (bits[3:2] == 2'b00 && esc_seen)
			begin
				esc_seen = 1'b0;
				nulls_in_row++;
			end
			else
			begin
				if (esc_seen)
					report_other("ESC followed by a code other than FCT");
				esc_seen = 1'b0;
				nulls_in_row = 0;
				got_data.push_back('0);
				if (bits[3:2] == 2'b00)
					got_kind.push_back(char_fct);
				else if (bits[3:2] == 2'b01)
					got_kind.push_back(char_eop);
				else
					got_kind.push_back(char_eep);
			end
		end
	endtask

	task automatic take_bit(input logic b);
		bits[nb] = b;
		nb++;
		if (nb == 2)
			len = bits[1] ? int'(len_ctrl) : int'(len_data);
		else if (nb >= 4 && nb == len)
		begin
			decode_char();
			nb = 0;
		end
	endtask

	// One bit per change of either wire, never both
	always @(negedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			prev_d = 1'b0;
			prev_s = 1'b0;
			nb = 0;
			run_par = 1'b0;
			esc_seen = 1'b0;
		end
		else
		begin
			if (tx_ready)
				ready_count++;
			if (dout !== prev_d && sout !== prev_s)
				report_other("Both dout and sout changed in one bit period");
			else if (dout !== prev_d || sout !== prev_s)
				take_bit(dout);
			prev_d = dout;
			prev_s = sout;
		end
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------

	task automatic after_edge();
		@(posedge pclk_tx);
		#1;
	endtask

	task automatic wait_ready();
		int cnt;
		bit found;
		cnt = 0;
		found = 1'b0;
		while (!found && cnt < 600)
		begin
			@(negedge pclk_tx);
			found = tx_ready;
			cnt++;
		end
		if (!found)
			report_other("Timeout waiting for tx_ready");
		after_edge();
	endtask

	task automatic wait_credit(input logic [2:0] exp);
		int cnt;
		cnt = 0;
		while (fct_credit !== exp && cnt < 300)
		begin
			@(negedge pclk_tx);
			cnt++;
		end
		if (fct_credit !== exp)
			report_other("Timeout waiting for fct_credit to settle");
	endtask

	// Three NULLs in a row mark an idle link
	task automatic wait_idle();
		int cnt;
		cnt = 0;
		while (nulls_in_row < 3 && cnt < 2000)
		begin
			@(posedge pclk_tx);
			cnt++;
		end
		if (nulls_in_row < 3)
			report_other("Timeout waiting for NULLs on the link");
	endtask

	// Wires must hold while send_null_tx is low
	task automatic freeze_check();
		logic d0;
		logic s0;
		int n;
		send_null_tx = 1'b0;
		d0 = dout;
		s0 = sout;
		n = 4 + ($random(seed) & 7);
		for (int k = 0; k < n; k++)
		begin
			@(negedge pclk_tx);
			if (dout !== d0 || sout !== s0)
				report_other("Data-strobe pair moved while send_null_tx was low");
		end
		after_edge();
		send_null_tx = 1'b1;
	endtask

	task automatic run_entry(input int e);
		logic [8:0] c;
		nulls_in_row = 0;
		ready_count = 0;
		got_kind.delete();
		got_data.delete();
		exp_kind.delete();
		exp_data.delete();
		// Pending FCTs go out ahead of any N-char
		if (t_fct[e])
		begin
			for (int i = 0; i < model_credit; i++)
			begin
				exp_kind.push_back(char_fct);
				exp_data.push_back('0);
			end
		end
		for (int i = 0; i < t_nchar[e]; i++)
		begin
			c = t_chars[e][i];
			exp_kind.push_back(!c[8] ? char_data : (c[0] ? char_eep : char_eop));
			exp_data.push_back(c[7:0]);
		end
		send_fct_tx = t_fct[e];
		send_char_tx = t_char[e];
		for (int i = 0; i < t_pulses[e]; i++)
		begin
			send_fct_now = 1'b1;
			after_edge();
			send_fct_now = 1'b0;
			repeat (1 + ($random(seed) & 3))
				after_edge();
		end
		if (t_pulses[e] >= int'(fct_credit_max))
		begin
			wait_credit(fct_credit_max);
			model_credit = fct_credit_max;
		end
		for (int i = 0; i < t_nchar[e]; i++)
		begin
			tx_valid = 1'b1;
			tx_data = t_chars[e][i][7:0];
			tx_eop = t_chars[e][i][8];
			wait_ready();
			tx_valid = 1'b0;
			if (t_pause[e] && i == 1)
				freeze_check();
		end
		wait_idle();
		if (t_fct[e])
			model_credit = 0;
		if (got_kind.size() != exp_kind.size())
			report_other($sformatf("Entry %0d decoded %0d characters instead of %0d",
				e, got_kind.size(), exp_kind.size()));
		else
		begin
			for (int i = 0; i < exp_kind.size(); i++)
			begin
				check_kind(got_kind[i], exp_kind[i]);
				if (exp_kind[i] == char_data)
					check_data(got_data[i], exp_data[i]);
			end
		end
		if (ready_count != t_nchar[e])
			report_other($sformatf("Entry %0d saw %0d tx_ready pulses instead of %0d",
				e, ready_count, t_nchar[e]));
		@(negedge pclk_tx);
		check_credit(fct_credit, model_credit[2:0]);
		// Next entry drives just after a rising edge
		after_edge();
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial
	begin
		enable_tx = 1'b0;
		send_null_tx = 1'b1;
		send_fct_tx = 1'b0;
		send_char_tx = 1'b0;
		send_fct_now = 1'b0;
		tx_valid = 1'b0;
		tx_data = '0;
		tx_eop = 1'b0;
		repeat (3)
			@(posedge pclk_tx);
		#1;
		enable_tx = 1'b1;
		for (int e = 0; e < num_entries; e++)
			run_entry(e);
		$display("Errors: kind %0d, data %0d, credit %0d, other %0d",
			kind_errors, data_errors, credit_errors, other_errors);
		if (kind_errors + data_errors + credit_errors + other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* spw_tx_top.f */
src/spw_tx_pkg.sv
src/tx_fct_send.sv
src/tx_char_select.sv
src/tx_char_encode.sv
src/tx_ds_serializer.sv
src/spw_tx_top.sv
dv/spw_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SpaceWire transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module spw_tx_tb \
	-f spw_tx_top.f -o spw_tx_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/spw_tx_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi
